// ==== Makefile ====
TOP = tbAlu

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f alu.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f alu.f --top-module $(TOP) -Mdir obj_dir
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir

// ==== alu.f ====
common/aluPkg.sv
common/shiftCtrlIf.sv
shift/shiftCounter.sv
shift/shiftUnit.sv
design/arithUnit.sv
design/logicUnit.sv
design/resultStage.sv
design/aluControl.sv
design/aluTop.sv
verif/tbClock.sv
verif/tbAlu.sv

// ==== common/aluPkg.sv ====
package aluPkg;

  // Datapath widths
  localparam int dataWidth = 32;
  localparam int shiftAmtWidth = 5;
  localparam int cmdWidth = 4;

  typedef logic [dataWidth-1:0] word_t;
  typedef logic [shiftAmtWidth-1:0] shiftAmt_t;

  // SHFT is the only code that needs the fourth bit
  typedef enum logic [cmdWidth-1:0] {
    cmdAdd  = 4'd0,
    cmdSub  = 4'd1,
    cmdXor  = 4'd2,
    cmdSlt  = 4'd3,
    cmdAnd  = 4'd4,
    cmdNand = 4'd5,
    cmdNor  = 4'd6,
    cmdOr   = 4'd7,
    cmdShft = 4'd8
  } command_t;

  // Controller states
  typedef enum logic {
    stIdle  = 1'b0,
    stShift = 1'b1
  } ctrlState_t;

endpackage

// ==== common/shiftCtrlIf.sv ====
`timescale 1ns/1ps

interface shiftCtrlIf;
  logic load;
  logic step;
  aluPkg::shiftAmt_t amount;
  logic countDone;

  modport ctrl (
    output load,
    output step,
    input  countDone
  );

  modport counter (
    input  load,
    input  step,
    input  amount,
    output countDone
  );

  modport shifter (
    input load,
    input step
  );
endinterface

// ==== design/aluControl.sv ====
`timescale 1ns/1ps

module aluControl (
  input  logic              clock,
  input  logic              rstN,
  input  logic              start,
  input  aluPkg::command_t  command,
  shiftCtrlIf.ctrl          ctrl,
  output logic              capture,
  output logic              done,
  output logic              busy
);

  aluPkg::ctrlState_t state;
  aluPkg::ctrlState_t nextState;
  logic               isIdle;
  logic               isShift;

  assign isIdle  = (state == aluPkg::stIdle);
  assign isShift = (command == aluPkg::cmdShft);

  // A shift loads the counter and shifter; everything else captures at once
  assign ctrl.load = isIdle && start && isShift;
  assign ctrl.step = !isIdle && !ctrl.countDone;

  assign capture = isIdle ? (start && !isShift) : ctrl.countDone;
  assign busy    = !isIdle;

  always_comb begin
    nextState = state;
    case (state)
      aluPkg::stIdle: begin
        if (ctrl.load) begin
          nextState = aluPkg::stShift;
        end
      end
      aluPkg::stShift: begin
        if (ctrl.countDone) begin
          nextState = aluPkg::stIdle;
        end
      end
      default: nextState = aluPkg::stIdle;
    endcase
  end

  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      state <= aluPkg::stIdle;
      done  <= 1'b0;
    end else begin
      state <= nextState;
      done  <= capture;
    end
  end

endmodule

// ==== design/aluTop.sv ====
`timescale 1ns/1ps

module aluTop (
  input  logic                       clock,
  input  logic                       rstN,
  input  logic                       start,
  input  logic [aluPkg::cmdWidth-1:0] command,
  input  aluPkg::word_t              operandA,
  input  aluPkg::word_t              operandB,
  output aluPkg::word_t              result,
  output logic                       carryout,
  output logic                       zero,
  output logic                       overflow,
  output logic                       done,
  output logic                       busy
);

  aluPkg::command_t cmdEnum;
  logic             capture;
  aluPkg::word_t    sum;
  logic             lessThan;
  logic             arithCarry;
  logic             arithOverflow;
  aluPkg::word_t    logicOut;
  aluPkg::word_t    shifted;

  shiftCtrlIf shiftBus ();

  // Codes 9 to 15 pass through the cast unchanged and fall to the defaults below
  assign cmdEnum = aluPkg::command_t'(command);
  assign shiftBus.amount = operandB[aluPkg::shiftAmtWidth-1:0];

  aluControl i_aluControl (
    .clock   (clock),
    .rstN    (rstN),
    .start   (start),
    .command (cmdEnum),
    .ctrl    (shiftBus.ctrl),
    .capture (capture),
    .done    (done),
    .busy    (busy)
  );

  shiftCounter i_shiftCounter (
    .clock (clock),
    .rstN  (rstN),
    .bus   (shiftBus.counter)
  );

  shiftUnit i_shiftUnit (
    .clock    (clock),
    .rstN     (rstN),
    .bus      (shiftBus.shifter),
    .operandA (operandA),
    .shifted  (shifted)
  );

  arithUnit i_arithUnit (
    .operandA (operandA),
    .operandB (operandB),
    .command  (cmdEnum),
    .sum      (sum),
    .lessThan (lessThan),
    .carryout (arithCarry),
    .overflow (arithOverflow)
  );

  logicUnit i_logicUnit (
    .operandA (operandA),
    .operandB (operandB),
    .command  (cmdEnum),
    .logicOut (logicOut)
  );

  resultStage i_resultStage (
    .clock         (clock),
    .rstN          (rstN),
    .capture       (capture),
    .command       (cmdEnum),
    .sum           (sum),
    .lessThan      (lessThan),
    .arithCarry    (arithCarry),
    .arithOverflow (arithOverflow),
    .logicOut      (logicOut),
    .shifted       (shifted),
    .result        (result),
    .carryout      (carryout),
    .zero          (zero),
    .overflow      (overflow)
  );

endmodule

// ==== design/arithUnit.sv ====
`timescale 1ns/1ps

module arithUnit (
  input  aluPkg::word_t     operandA,
  input  aluPkg::word_t     operandB,
  input  aluPkg::command_t  command,
  output aluPkg::word_t     sum,
  output logic              lessThan,
  output logic              carryout,
  output logic              overflow
);

  logic                          subtract;
  aluPkg::word_t                 addendB;
  logic [aluPkg::dataWidth:0]    fullSum;

  // SLT is a subtract whose sign is all that matters
  assign subtract = (command == aluPkg::cmdSub) || (command == aluPkg::cmdSlt);
  assign addendB  = subtract ? ~operandB : operandB;

  // One adder, carry-in of 1 completes the two's complement
  assign fullSum  = {1'b0, operandA} + {1'b0, addendB} + {{aluPkg::dataWidth{1'b0}}, subtract};
  assign sum      = fullSum[aluPkg::dataWidth-1:0];
  assign carryout = fullSum[aluPkg::dataWidth];

  // Same-sign inputs giving an opposite-sign sum
  assign overflow = (operandA[aluPkg::dataWidth-1] == addendB[aluPkg::dataWidth-1]) &&
                    (sum[aluPkg::dataWidth-1] != operandA[aluPkg::dataWidth-1]);

  assign lessThan = sum[aluPkg::dataWidth-1] ^ overflow;

endmodule

// ==== design/logicUnit.sv ====
`timescale 1ns/1ps

module logicUnit (
  input  aluPkg::word_t     operandA,
  input  aluPkg::word_t     operandB,
  input  aluPkg::command_t  command,
  output aluPkg::word_t     logicOut
);

  aluPkg::word_t andBits;
  aluPkg::word_t orBits;

  assign andBits = operandA & operandB;
  assign orBits  = operandA | operandB;

  always_comb begin
    case (command)
      aluPkg::cmdAnd:  logicOut = andBits;
      aluPkg::cmdNand: logicOut = ~andBits;
      aluPkg::cmdOr:   logicOut = orBits;
      aluPkg::cmdNor:  logicOut = ~orBits;
      aluPkg::cmdXor:  logicOut = operandA ^ operandB;
      default:         logicOut = '0;
    endcase
  end

endmodule

// ==== design/resultStage.sv ====
`timescale 1ns/1ps

module resultStage (
  input  logic              clock,
  input  logic              rstN,
  input  logic              capture,
  input  aluPkg::command_t  command,
  input  aluPkg::word_t     sum,
  input  logic              lessThan,
  input  logic              arithCarry,
  input  logic              arithOverflow,
  input  aluPkg::word_t     logicOut,
  input  aluPkg::word_t     shifted,
  output aluPkg::word_t     result,
  output logic              carryout,
  output logic              zero,
  output logic              overflow
);

  aluPkg::word_t selResult;
  logic          isAddSub;

  assign isAddSub = (command == aluPkg::cmdAdd) || (command == aluPkg::cmdSub);

  always_comb begin
    case (command)
      aluPkg::cmdAdd,
      aluPkg::cmdSub:  selResult = sum;
      aluPkg::cmdSlt:  selResult = {{(aluPkg::dataWidth-1){1'b0}}, lessThan};
      aluPkg::cmdXor,
      aluPkg::cmdAnd,
      aluPkg::cmdNand,
      aluPkg::cmdNor,
      aluPkg::cmdOr:   selResult = logicOut;
      aluPkg::cmdShft: selResult = shifted;
      // Undefined codes
      default:         selResult = '0;
    endcase
  end

  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      result   <= '0;
      carryout <= 1'b0;
      zero     <= 1'b0;
      overflow <= 1'b0;
    end else if (capture) begin
      result   <= selResult;
      carryout <= isAddSub && arithCarry;
      overflow <= isAddSub && arithOverflow;
      zero     <= (selResult == '0);
    end
  end

endmodule

// ==== shift/shiftCounter.sv ====
`timescale 1ns/1ps

module shiftCounter (
  input  logic          clock,
  input  logic          rstN,
  shiftCtrlIf.counter   bus
);

  aluPkg::shiftAmt_t remaining;

  // Places still to shift
  assign bus.countDone = (remaining == '0);

  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      remaining <= '0;
    end else if (bus.load) begin
      remaining <= bus.amount;
    end else if (bus.step && !bus.countDone) begin
      remaining <= remaining - 1'b1;
    end
  end

endmodule

// ==== shift/shiftUnit.sv ====
`timescale 1ns/1ps

module shiftUnit (
  input  logic           clock,
  input  logic           rstN,
  shiftCtrlIf.shifter    bus,
  input  aluPkg::word_t  operandA,
  output aluPkg::word_t  shifted
);

  aluPkg::word_t shiftReg;

  assign shifted = shiftReg;

  // Logical left shift, zero fill, one place per step
  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      shiftReg <= '0;
    end else if (bus.load) begin
      shiftReg <= operandA;
    end else if (bus.step) begin
      shiftReg <= {shiftReg[aluPkg::dataWidth-2:0], 1'b0};
    end
  end

endmodule

// ==== verif/tbAlu.sv ====
`timescale 1ns/1ps

module tbAlu;

  localparam longint maxSigned = 64'sd2147483647;
  localparam longint minSigned = -64'sd2147483648;

  logic          clock;
  logic          rstN;
  logic          start;
  logic [3:0]    command;
  aluPkg::word_t operandA;
  aluPkg::word_t operandB;
  aluPkg::word_t result;
  logic          carryout;
  logic          zero;
  logic          overflow;
  logic          done;
  logic          busy;

  // Expected response of the operation in flight
  aluPkg::word_t expResult;
  logic          expCarry;
  logic          expOverflow;
  logic          expBusy;
  int            expLatency;
  int            startCycle;
  int            cycleCount;
  logic          opActive;
  logic          started;

  int            resultErrors;
  int            flagErrors;
  int            timingErrors;
  int            resetErrors;
  int            timeouts;
  int            errorTotal;
  int            waited;
  integer        seed;
  aluPkg::word_t ra;
  aluPkg::word_t rb;

  tbClock i_tbClock (
    .clock (clock),
    .rstN  (rstN)
  );

  aluTop i_aluTop (
    .clock    (clock),
    .rstN     (rstN),
    .start    (start),
    .command  (command),
    .operandA (operandA),
    .operandB (operandB),
    .result   (result),
    .carryout (carryout),
    .zero     (zero),
    .overflow (overflow),
    .done     (done),
    .busy     (busy)
  );

  always @(posedge clock) begin
    cycleCount <= cycleCount + 1;
  end

  function automatic aluPkg::word_t resultModel(input logic [3:0] cmd,
                                                input aluPkg::word_t a,
                                                input aluPkg::word_t b);
    case (cmd)
      aluPkg::cmdAdd:  return a + b;
      aluPkg::cmdSub:  return a - b;
      aluPkg::cmdXor:  return a ^ b;
      aluPkg::cmdSlt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      aluPkg::cmdAnd:  return a & b;
      aluPkg::cmdNand: return ~(a & b);
      aluPkg::cmdNor:  return ~(a | b);
      aluPkg::cmdOr:   return a | b;
      aluPkg::cmdShft: return a << b[4:0];
      default:         return '0;
    endcase
  endfunction

  // Carry out of the 33-bit sum; for SUB that means no borrow
  function automatic logic carryModel(input logic [3:0] cmd,
                                      input aluPkg::word_t a,
                                      input aluPkg::word_t b);
    logic [32:0] wide;
    wide = {1'b0, a} + {1'b0, b};
    if (cmd == aluPkg::cmdAdd) begin
      return wide[32];
    end
    if (cmd == aluPkg::cmdSub) begin
      return a >= b;
    end
    return 1'b0;
  endfunction

  // Signed result that does not fit in 32 bits
  function automatic logic overflowModel(input logic [3:0] cmd,
                                         input aluPkg::word_t a,
                                         input aluPkg::word_t b);
    longint sa;
    longint sb;
    longint sres;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    if (cmd == aluPkg::cmdAdd) begin
      sres = sa + sb;
    end else if (cmd == aluPkg::cmdSub) begin
      sres = sa - sb;
    end else begin
      return 1'b0;
    end
    return (sres > maxSigned) || (sres < minSigned);
  endfunction

  task automatic runOp(input logic [3:0] cmd, input aluPkg::word_t a,
                       input aluPkg::word_t b, input logic pokeStart);
    int          opWait;
    logic [31:0] rnd;
    @(posedge clock);
    #1;
    command     = cmd;
    operandA    = a;
    operandB    = b;
    expResult   = resultModel(cmd, a, b);
    expCarry    = carryModel(cmd, a, b);
    expOverflow = overflowModel(cmd, a, b);
    expBusy     = (cmd == aluPkg::cmdShft);
    expLatency  = expBusy ? int'(b[4:0]) + 2 : 1;
    startCycle  = cycleCount;
    opActive    = 1'b1;
    started     = 1'b1;
    start       = 1'b1;
    @(posedge clock);
    #1;
    start  = 1'b0;
    opWait = 0;
    while (!done && opWait < 64) begin
      // Stray start pulses while busy must be ignored
      rnd   = $random(seed);
      start = pokeStart && busy && rnd[0];
      @(posedge clock);
      #1;
      opWait++;
    end
    start = 1'b0;
    if (!done) begin
      timeouts++;
      $display("Timeout at %0t: done never came for command %0d", $time, cmd);
    end
    @(posedge clock);
    #1;
    opActive = 1'b0;
  endtask

  resetState: assert property (@(posedge clock) disable iff (!rstN)
    !started |-> (!done && !busy && result == '0))
    else begin
      resetErrors++;
      $display("[FAIL] %0t: outputs not idle after reset", $time);
    end

  resultValue: assert property (@(posedge clock) disable iff (!rstN)
    done |-> result == expResult)
    else begin
      resultErrors++;
      $display("[FAIL] %0t: result %h, expected %h", $time, $sampled(result),
               $sampled(expResult));
    end

  flagValues: assert property (@(posedge clock) disable iff (!rstN)
    done |-> (carryout == expCarry && overflow == expOverflow &&
              zero == (expResult == '0)))
    else begin
      flagErrors++;
      $display("[FAIL] %0t: flags c%b v%b z%b, expected c%b v%b for %h", $time,
               $sampled(carryout), $sampled(overflow), $sampled(zero),
               $sampled(expCarry), $sampled(expOverflow), $sampled(expResult));
    end

  doneTiming: assert property (@(posedge clock) disable iff (!rstN)
    done |-> (opActive && (cycleCount - startCycle) == expLatency))
    else begin
      timingErrors++;
      $display("[FAIL] %0t: done after %0d cycles, expected %0d", $time,
               $sampled(cycleCount) - startCycle, expLatency);
    end

  busyLevel: assert property (@(posedge clock) disable iff (!rstN)
    (opActive && (cycleCount - startCycle) >= 1) |->
      busy == (expBusy && ((cycleCount - startCycle) < expLatency)))
    else begin
      timingErrors++;
      $display("[FAIL] %0t: busy %b at cycle %0d of %0d", $time, $sampled(busy),
               $sampled(cycleCount) - startCycle, expLatency);
    end

  initial begin
    seed         = 32'h6e28;
    start        = 1'b0;
    command      = 4'd0;
    operandA     = '0;
    operandB     = '0;
    expResult    = '0;
    expCarry     = 1'b0;
    expOverflow  = 1'b0;
    expBusy      = 1'b0;
    expLatency   = 0;
    startCycle   = 0;
    opActive     = 1'b0;
    started      = 1'b0;
    resultErrors = 0;
    flagErrors   = 0;
    timingErrors = 0;
    resetErrors  = 0;
    timeouts     = 0;

    waited = 0;
    while (rstN !== 1'b1 && waited < 20) begin
      @(posedge clock);
      waited++;
    end
    if (rstN !== 1'b1) begin
      timeouts++;
      $display("Timeout: reset was never released");
    end
    repeat (3) @(posedge clock);

    for (int c = 0; c < 8; c++) begin
      runOp(4'(c), 32'h7fff_ffff, 32'h0000_0001, 1'b0);
      repeat (4) begin
        ra = $random(seed);
        rb = $random(seed);
        runOp(4'(c), ra, rb, 1'b0);
      end
    end

    // Overflow with both operand signs, and an exact zero
    runOp(aluPkg::cmdAdd, 32'h8000_0000, 32'h8000_0000, 1'b0);
    runOp(aluPkg::cmdAdd, 32'hffff_ffff, 32'h0000_0001, 1'b0);
    runOp(aluPkg::cmdSub, 32'h8000_0000, 32'h0000_0001, 1'b0);
    runOp(aluPkg::cmdSub, 32'h7fff_ffff, 32'hffff_ffff, 1'b0);
    runOp(aluPkg::cmdSub, 32'h0000_0005, 32'h0000_0005, 1'b0);

    runOp(aluPkg::cmdShft, 32'hdead_beef, 32'd0, 1'b1);
    runOp(aluPkg::cmdShft, 32'hdead_beef, 32'd1, 1'b1);
    runOp(aluPkg::cmdShft, 32'hdead_beef, 32'd31, 1'b1);
    repeat (6) begin
      ra = $random(seed);
      rb = $random(seed);
      runOp(aluPkg::cmdShft, ra, rb, 1'b1);
    end

    for (int c = 9; c < 16; c++) begin
      ra = $random(seed);
      rb = $random(seed);
      runOp(4'(c), ra, rb, 1'b0);
    end

    errorTotal = resultErrors + flagErrors + timingErrors + resetErrors + timeouts;
    $display("Errors: result %0d, flags %0d, timing %0d, reset %0d, timeouts %0d",
             resultErrors, flagErrors, timingErrors, resetErrors, timeouts);
    if (errorTotal == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== verif/tbClock.sv ====
`timescale 1ns/1ps

module tbClock (
  output logic clock,
  output logic rstN
);

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // Reset held for five rising edges, released just after the fifth
  initial begin
    rstN = 1'b0;
    repeat (5) @(posedge clock);
    #1;
    rstN = 1'b1;
  end

endmodule
